// ==== source/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// width of one fetch word and of a byte address
`define FETCH_XLEN 64

// width of one uncompressed instruction
`define FETCH_ILEN 32

// first address fetched after reset
// the pc register starts one word below this value,
// so the first sequential step lands here
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// step between two sequential fetches
`define FETCH_STEP 4

`endif

// ==== source/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // byte address as seen by the fetch unit
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // aligned double word returned by the instruction memory
    typedef logic [`FETCH_XLEN-1:0] fword_t;

    // one instruction handed to decode
    typedef logic [`FETCH_ILEN-1:0] instr_t;

    // requester FSM
    // REQ_IDLE   nothing outstanding
    // REQ_WAIT   outstanding request still on the current path
    // REQ_STALE  outstanding request overtaken by a redirect
    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_STALE
    } req_state_t;

endpackage

// ==== source/pc_select.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module pc_select import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  issue_i,
    input  logic  intr_i,
    input  logic  jump_i,
    input  logic  trap_enter_i,
    input  logic  trap_return_i,
    input  addr_t jump_target_i,
    input  addr_t mtvec_i,
    input  addr_t mepc_i,
    output addr_t next_pc_o,
    output addr_t pc_o,
    output logic  redirect_o
);

    addr_t pc_q;
    addr_t redir_target;
    addr_t pend_pc_q;
    logic  pend_valid_q;

    // any redirect strobe in this cycle
    assign redirect_o = intr_i | jump_i | trap_enter_i | trap_return_i;

    // fixed priority of interrupt, jump, trap entry and trap return
    always_comb begin
        if (intr_i) begin
            redir_target = mtvec_i;
        end else if (jump_i) begin
            redir_target = jump_target_i;
        end else if (trap_enter_i) begin
            redir_target = mtvec_i;
        end else if (trap_return_i) begin
            redir_target = mepc_i;
        end else begin
            redir_target = pc_q + addr_t'(`FETCH_STEP);
        end
    end

    // a fresh redirect beats a pending one, which beats pc+4
    always_comb begin
        if (redirect_o) begin
            next_pc_o = redir_target;
        end else if (pend_valid_q) begin
            next_pc_o = pend_pc_q;
        end else begin
            next_pc_o = pc_q + addr_t'(`FETCH_STEP);
        end
    end

    // pc of the latest issued request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= addr_t'(`FETCH_RESET_PC) - addr_t'(`FETCH_STEP);
        end else if (issue_i) begin
            pc_q <= next_pc_o;
        end
    end

    // redirect seen without an issue waits here for the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid_q <= 1'b0;
        end else if (issue_i) begin
            pend_valid_q <= 1'b0;
        end else if (redirect_o) begin
            pend_valid_q <= 1'b1;
        end
    end

    // later redirect overwrites the stored target
    always_ff @(posedge clk) begin
        if (!issue_i && redirect_o) begin
            pend_pc_q <= redir_target;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== source/fetch_requester.sv ====
`timescale 1ns/1ps

module fetch_requester import fetch_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_n_i,
    input  logic redirect_i,
    input  logic mem_rvalid_i,
    output logic issue_o,
    output logic accept_o
);

    req_state_t state_q;
    req_state_t state_d;
    logic       idle;
    logic       wait_cur;

    assign idle     = (state_q == REQ_IDLE);
    assign wait_cur = (state_q == REQ_WAIT);

    // new request when the slot is free or frees up this cycle
    // memory never answers in idle, so rvalid alone marks a free slot
    assign issue_o = stall_n_i & (idle | mem_rvalid_i);

    // response goes to decode only if its path is still current
    assign accept_o = wait_cur & mem_rvalid_i & ~redirect_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            REQ_IDLE: begin
                if (issue_o) begin
                    state_d = REQ_WAIT;
                end
            end
            REQ_WAIT: begin
                if (mem_rvalid_i) begin
                    // a same-cycle redirect is folded into the new request
                    if (issue_o) begin
                        state_d = REQ_WAIT;
                    end else begin
                        state_d = REQ_IDLE;
                    end
                end else if (redirect_i) begin
                    state_d = REQ_STALE;
                end
            end
            REQ_STALE: begin
                // drop the old response, then carry on
                if (mem_rvalid_i) begin
                    if (issue_o) begin
                        state_d = REQ_WAIT;
                    end else begin
                        state_d = REQ_IDLE;
                    end
                end
            end
            default: begin
                state_d = REQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= REQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== source/instr_align.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module instr_align import fetch_pkg::*; (
    input  addr_t  pc_i,
    input  fword_t rdata_i,
    input  logic   accept_i,
    output instr_t instr_o,
    output addr_t  instr_pc_o,
    output logic   instr_valid_o
);

    instr_t lo_half;
    instr_t hi_half;

    // two instructions per fetch word, lower address in the low half
    assign lo_half = rdata_i[`FETCH_ILEN-1:0];
    assign hi_half = rdata_i[2*`FETCH_ILEN-1:`FETCH_ILEN];

    // pc bit 2 picks the word within the double word
    always_comb begin
        if (pc_i[2]) begin
            instr_o = hi_half;
        end else begin
            instr_o = lo_half;
        end
    end

    // the pc travels with its instruction
    assign instr_pc_o = pc_i;

    // one strobe per accepted response
    assign instr_valid_o = accept_i;

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall_n_i,
    input  logic   intr_i,
    input  logic   jump_i,
    input  addr_t  jump_target_i,
    input  logic   trap_enter_i,
    input  logic   trap_return_i,
    input  addr_t  mtvec_i,
    input  addr_t  mepc_i,
    input  logic   mem_rvalid_i,
    input  fword_t mem_rdata_i,
    output logic   mem_req_o,
    output addr_t  mem_addr_o,
    output logic   instr_valid_o,
    output instr_t instr_o,
    output addr_t  instr_pc_o
);

    addr_t pc_q;
    logic  redirect;
    logic  accept;

    // next pc goes straight out as the memory address
    pc_select u_pc_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_i       (mem_req_o),
        .intr_i        (intr_i),
        .jump_i        (jump_i),
        .trap_enter_i  (trap_enter_i),
        .trap_return_i (trap_return_i),
        .jump_target_i (jump_target_i),
        .mtvec_i       (mtvec_i),
        .mepc_i        (mepc_i),
        .next_pc_o     (mem_addr_o),
        .pc_o          (pc_q),
        .redirect_o    (redirect)
    );

    // issue strobe is the memory request itself
    fetch_requester u_fetch_requester (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_n_i    (stall_n_i),
        .redirect_i   (redirect),
        .mem_rvalid_i (mem_rvalid_i),
        .issue_o      (mem_req_o),
        .accept_o     (accept)
    );

    instr_align u_instr_align (
        .pc_i          (pc_q),
        .rdata_i       (mem_rdata_i),
        .accept_i      (accept),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

endmodule

// ==== dv/fetch_asserts.sv ====
`timescale 1ns/1ps

module fetch_asserts import fetch_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  mem_req_i,
    input addr_t mem_addr_i,
    input logic  mem_rvalid_i,
    input logic  instr_valid_i
);

    logic outstanding_q;

    // one request in flight from mem_req until mem_rvalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_rvalid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_i |-> (mem_addr_i[1:0] == 2'b00))
        else $error("fetch address 0x%0h is not 4-byte aligned", mem_addr_i);

    a_valid_needs_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid_i |-> mem_rvalid_i)
        else $error("instruction strobe without a memory response");

    // a new request may only overlap the response that frees the slot
    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_i && outstanding_q) |-> mem_rvalid_i)
        else $error("second request while one is outstanding");

    a_no_valid_in_reset: assert property (@(posedge clk)
        !rst_n |-> !instr_valid_i)
        else $error("instruction strobe during reset");

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int HALF_PERIOD      = 50;
    localparam int RESET_CYCLES     = 8;
    localparam int DELIVERY_TIMEOUT = 40;

    typedef enum int {
        EV_NONE,
        EV_STALL,
        EV_JUMP,
        EV_TRAP_ENTER,
        EV_TRAP_RETURN,
        EV_INTR,
        EV_INTR_JUMP
    } ev_kind_t;

    // target is the pc expected next after a redirect row
    // gap is idle cycles after the event, or stall length for EV_STALL
    typedef struct {
        ev_kind_t kind;
        addr_t    target;
        int       gap;
    } stim_row_t;

    logic   clk;
    logic   rst_n;
    logic   stall_n_i;
    logic   intr_i, jump_i, trap_enter_i, trap_return_i;
    addr_t  jump_target_i, mtvec_i, mepc_i;
    logic   mem_rvalid_i;
    fword_t mem_rdata_i;
    logic   mem_req_o;
    addr_t  mem_addr_o;
    logic   instr_valid_o;
    instr_t instr_o;
    addr_t  instr_pc_o;

    // memory model and reference model state
    logic        mem_busy;
    int          mem_wait;
    addr_t       mem_addr_q;
    logic [31:0] lcg_state;
    addr_t       exp_pc;
    int          delivered;
    stim_row_t   stim_q[$];

    fetch_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .intr_i        (intr_i),
        .jump_i        (jump_i),
        .jump_target_i (jump_target_i),
        .trap_enter_i  (trap_enter_i),
        .trap_return_i (trap_return_i),
        .mtvec_i       (mtvec_i),
        .mepc_i        (mepc_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o)
    );

    bind fetch_top fetch_asserts u_fetch_asserts (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_i     (mem_req_o),
        .mem_addr_i    (mem_addr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .instr_valid_i (instr_valid_o)
    );

    initial clk = 1'b0;
    always #(HALF_PERIOD) clk = ~clk;

    // memory contents rule
    function automatic instr_t instr_at(input addr_t a);
        return a[31:0] ^ 32'hA5A5_0000;
    endfunction

    function automatic fword_t word_at(input addr_t a);
        addr_t base;
        base = {a[`FETCH_XLEN-1:3], 3'b000};
        return {instr_at(base + 64'd4), instr_at(base)};
    endfunction

    // lcg giving a latency of 1 to 4 cycles
    function automatic int random_latency();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 32'd4) + 1;
    endfunction

    function automatic logic is_redirect(input ev_kind_t kind);
        return (kind != EV_NONE) && (kind != EV_STALL);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // losing sources get distinct values so a wrong priority shows up
    task automatic drive_event(input ev_kind_t kind, input addr_t target);
        intr_i        = 1'b0;
        jump_i        = 1'b0;
        trap_enter_i  = 1'b0;
        trap_return_i = 1'b0;
        jump_target_i = target + 64'h100;
        mtvec_i       = target + 64'h200;
        mepc_i        = target + 64'h300;
        case (kind)
            EV_JUMP: begin
                jump_i        = 1'b1;
                jump_target_i = target;
            end
            EV_TRAP_ENTER: begin
                trap_enter_i = 1'b1;
                mtvec_i      = target;
            end
            EV_TRAP_RETURN: begin
                trap_return_i = 1'b1;
                mepc_i        = target;
            end
            EV_INTR: begin
                intr_i  = 1'b1;
                mtvec_i = target;
            end
            EV_INTR_JUMP: begin
                intr_i  = 1'b1;
                jump_i  = 1'b1;
                mtvec_i = target;
            end
            default: begin
            end
        endcase
    endtask

    // drive one cycle on the falling edge and observe it mid low phase
    task automatic apply_cycle(input ev_kind_t kind, input addr_t target, input logic stall_n);
        @(negedge clk);
        stall_n_i = stall_n;
        drive_event(kind, target);
        mem_rvalid_i = 1'b0;
        if (mem_busy && mem_wait == 1) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = word_at(mem_addr_q);
            mem_busy     = 1'b0;
        end else if (mem_busy) begin
            mem_wait = mem_wait - 1;
        end
        #(HALF_PERIOD / 2);
        // anything delivered from here on belongs to the new path
        if (is_redirect(kind)) begin
            exp_pc = target;
        end
        if (instr_valid_o) begin
            compare_values("instr_pc_o", instr_pc_o, exp_pc);
            compare_values("instr_o", 64'(instr_o), 64'(instr_at(exp_pc)));
            // address that was sent out for the delivered response
            compare_values("mem_addr_o", mem_addr_q, exp_pc);
            exp_pc    = exp_pc + 64'd4;
            delivered = delivered + 1;
        end
        if (mem_req_o && !stall_n) begin
            report_failure("memory request issued while stall_n_i is low");
        end else if (mem_req_o && mem_busy) begin
            report_failure("memory request issued while another one is outstanding");
        end else if (mem_req_o) begin
            mem_busy   = 1'b1;
            mem_addr_q = mem_addr_o;
            mem_wait   = random_latency();
        end
    endtask

    task automatic wait_delivery(input int count);
        int goal;
        int cycles;
        goal   = delivered + count;
        cycles = 0;
        while (delivered < goal) begin
            if (cycles >= DELIVERY_TIMEOUT) begin
                report_failure("timeout while waiting for an instruction delivery");
            end else begin
                apply_cycle(EV_NONE, '0, 1'b1);
                cycles = cycles + 1;
            end
        end
    endtask

    task automatic add_row(input ev_kind_t kind, input addr_t target, input int gap);
        stim_row_t row;
        row.kind   = kind;
        row.target = target;
        row.gap    = gap;
        stim_q.push_back(row);
    endtask

    initial begin
        stim_row_t row;
        int        stall_start;
        rst_n        = 1'b0;
        stall_n_i    = 1'b0;
        drive_event(EV_NONE, '0);
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_busy     = 1'b0;
        mem_wait     = 0;
        mem_addr_q   = '0;
        lcg_state    = 32'd4;
        exp_pc       = `FETCH_RESET_PC;
        delivered    = 0;

        add_row(EV_NONE,        64'h0,                  12);
        add_row(EV_JUMP,        64'h0000_0000_8000_1004, 8);
        add_row(EV_NONE,        64'h0,                   3);
        add_row(EV_TRAP_ENTER,  64'h0000_0000_8000_0100, 6);
        add_row(EV_TRAP_RETURN, 64'h0000_0000_8000_1010, 5);
        add_row(EV_INTR,        64'h0000_0000_8000_0200, 7);
        add_row(EV_INTR_JUMP,   64'h0000_0000_8000_0300, 6);
        add_row(EV_STALL,       64'h0,                   8);
        add_row(EV_JUMP,        64'h0000_0001_2345_6780, 1);
        // back to back redirects where the second one must win
        add_row(EV_JUMP,        64'h0000_0000_8000_3000, 0);
        add_row(EV_TRAP_ENTER,  64'h0000_0000_8000_4004, 5);
        add_row(EV_STALL,       64'h0,                   3);
        add_row(EV_JUMP,        64'h0000_0000_8000_5008, 2);
        add_row(EV_TRAP_RETURN, 64'h0000_0000_8000_6000, 1);
        add_row(EV_INTR_JUMP,   64'h0000_0000_8000_7004, 9);
        add_row(EV_STALL,       64'h0,                  10);
        add_row(EV_NONE,        64'h0,                   6);

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;

        foreach (stim_q[i]) begin
            row = stim_q[i];
            if (row.kind == EV_STALL) begin
                stall_start = delivered;
                for (int c = 0; c < row.gap; c++) begin
                    apply_cycle(EV_NONE, '0, 1'b0);
                end
                if (delivered - stall_start > 1) begin
                    report_failure("more than one instruction delivered while stalled");
                end
            end else begin
                apply_cycle(row.kind, row.target, 1'b1);
                for (int c = 0; c < row.gap; c++) begin
                    apply_cycle(EV_NONE, '0, 1'b1);
                end
            end
            if (row.gap != 0) begin
                wait_delivery(1);
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/fetch_pkg.sv
source/pc_select.sv
source/fetch_requester.sv
source/instr_align.sv
source/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/pc_select.sv
      - source/fetch_requester.sv
      - source/instr_align.sv
      - source/fetch_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/fetch_asserts.sv
      - dv/fetch_tb.sv
